// File: rtl/gpio_pkg.sv
// GPIO pin description shared by RTL and testbench
// All pins share one data width; the bus data word matches it
// Synchronizer depth is fixed here and must stay at 2 or more

package gpio_pkg;

    //////////////////////////////
    // Pin count and data width
    //////////////////////////////

    // Number of GPIO pins, also the bus data width
    localparam int GPIO_W = 8;

    // Flip-flops in the input synchronizer chain
    localparam int SYNC_STAGES = 2;

endpackage : gpio_pkg

// File: rtl/bus_pkg.sv
// Register bus description: opcodes, register map, arbiter states
// Addresses 6 and 7 are unmapped and read back as zero
// REG_IN is read only, REG_EDGE is write-one-to-clear

package bus_pkg;

    // Register address width
    localparam int REG_ADDR_W = 3;

    // Bus opcode
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_t;

    // Register map
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_OUT      = 3'd0,
        REG_OE       = 3'd1,
        REG_IEN      = 3'd2,
        REG_IN       = 3'd3,
        REG_EDGE     = 3'd4,
        REG_IRQ_MASK = 3'd5
    } gpio_reg_t;

    // Arbiter FSM
    typedef enum logic {
        ARB_IDLE   = 1'b0,
        ARB_ACCESS = 1'b1
    } arb_state_t;

endpackage : bus_pkg

// File: rtl/gpio_sync.sv
// Pin input synchronizer into the clk domain
// Disabled pins are forced low before the first flop
// Output lags an enabled pin change by SYNC_STAGES clock edges

`timescale 1ns/1ps

module gpio_sync import gpio_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [GPIO_W-1:0] gpio_in,
    input  logic [GPIO_W-1:0] gpio_ien,
    output logic [GPIO_W-1:0] gpio_sync_val
);

    // Synchronizer chain, stage 0 samples the pins
    logic [GPIO_W-1:0] sync_q [SYNC_STAGES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= '{default: '0};
        end else begin
            // Masking keeps idle pins from toggling the chain
            sync_q[0] <= gpio_in & gpio_ien;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Last stage is the stable value
    assign gpio_sync_val = sync_q[SYNC_STAGES-1];

endmodule : gpio_sync

// File: rtl/gpio_regs.sv
// GPIO register block on the internal register bus
// Writes land on the bus_en edge; read data is registered on the same edge
// Edge capture sees rising edges of the synchronized inputs only
// irq is a level, the OR of captured edges that are masked in

`timescale 1ns/1ps

module gpio_regs import gpio_pkg::*, bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // Register bus
    input  logic              bus_en,
    input  bus_op_t           bus_op,
    input  gpio_reg_t         bus_addr,
    input  logic [GPIO_W-1:0] bus_wdata,
    output logic [GPIO_W-1:0] bus_rdata,
    // Synchronizer side
    input  logic [GPIO_W-1:0] gpio_sync_val,
    output logic [GPIO_W-1:0] gpio_ien,
    // Pins and interrupt
    output logic [GPIO_W-1:0] gpio_out,
    output logic [GPIO_W-1:0] gpio_oe,
    output logic              irq
);

    //////////////////////////////
    // Register storage
    //////////////////////////////

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] oe_q;
    logic [GPIO_W-1:0] ien_q;
    logic [GPIO_W-1:0] mask_q;
    logic [GPIO_W-1:0] edge_q;
    // Previous synchronized input, for edge detect
    logic [GPIO_W-1:0] prev_q;

    logic              wr_en;
    logic [GPIO_W-1:0] edge_rise;
    logic [GPIO_W-1:0] edge_clr;
    logic [GPIO_W-1:0] rd_mux;

    assign wr_en = bus_en && (bus_op == BUS_WRITE);

    // 0 to 1 transitions of the synced inputs
    assign edge_rise = gpio_sync_val & ~prev_q;

    // Write-one-to-clear mask
    assign edge_clr = (wr_en && bus_addr == REG_EDGE) ? bus_wdata : '0;

    //////////////////////////////
    // Read decode
    //////////////////////////////

    always_comb begin
        case (bus_addr)
            REG_OUT:      rd_mux = out_q;
            REG_OE:       rd_mux = oe_q;
            REG_IEN:      rd_mux = ien_q;
            REG_IN:       rd_mux = gpio_sync_val;
            REG_EDGE:     rd_mux = edge_q;
            REG_IRQ_MASK: rd_mux = mask_q;
            // Unmapped addresses
            default:      rd_mux = '0;
        endcase
    end

    //////////////////////////////
    // Write and capture
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_q     <= '0;
            oe_q      <= '0;
            ien_q     <= '0;
            mask_q    <= '0;
            edge_q    <= '0;
            prev_q    <= '0;
            bus_rdata <= '0;
        end else begin
            prev_q <= gpio_sync_val;
            // New edge wins over a clear in the same cycle
            edge_q <= (edge_q & ~edge_clr) | edge_rise;
            if (wr_en) begin
                case (bus_addr)
                    REG_OUT:      out_q  <= bus_wdata;
                    REG_OE:       oe_q   <= bus_wdata;
                    REG_IEN:      ien_q  <= bus_wdata;
                    REG_IRQ_MASK: mask_q <= bus_wdata;
                    // REG_IN, REG_EDGE and holes are not plain stores
                    default:      ;
                endcase
            end
            // Read value from before any write in this cycle
            if (bus_en) begin
                bus_rdata <= rd_mux;
            end
        end
    end

    // Outputs straight from the registers
    assign gpio_out = out_q;
    assign gpio_oe  = oe_q;
    assign gpio_ien = ien_q;
    assign irq      = |(edge_q & mask_q);

endmodule : gpio_regs

// File: rtl/bus_arbiter.sv
// Two-port round-robin arbiter for the register bus
// Each port holds at most one request; it must wait for done before the next strobe
// Uncontended strobe to done is 2 cycles; a contended port waits 2 more
// rdata is only valid with done and is zero for writes

`timescale 1ns/1ps

module bus_arbiter import gpio_pkg::*, bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // Port a
    input  logic                  a_stb,
    input  bus_op_t               a_op,
    input  logic [REG_ADDR_W-1:0] a_addr,
    input  logic [GPIO_W-1:0]     a_wdata,
    output logic                  a_done,
    output logic [GPIO_W-1:0]     a_rdata,
    // Port b
    input  logic                  b_stb,
    input  bus_op_t               b_op,
    input  logic [REG_ADDR_W-1:0] b_addr,
    input  logic [GPIO_W-1:0]     b_wdata,
    output logic                  b_done,
    output logic [GPIO_W-1:0]     b_rdata,
    // Shared register bus
    output logic                  bus_en,
    output bus_op_t               bus_op,
    output gpio_reg_t             bus_addr,
    output logic [GPIO_W-1:0]     bus_wdata,
    input  logic [GPIO_W-1:0]     bus_rdata
);

    //////////////////////////////
    // Pending slots, index 0 = a
    //////////////////////////////

    logic [1:0]            stb_v;
    logic [1:0]            done_v;
    logic [1:0]            pend_q;
    bus_op_t               op_in    [2];
    logic [REG_ADDR_W-1:0] addr_in  [2];
    logic [GPIO_W-1:0]     wdata_in [2];
    bus_op_t               op_q     [2];
    logic [REG_ADDR_W-1:0] addr_q   [2];
    logic [GPIO_W-1:0]     wdata_q  [2];

    arb_state_t            state_q;
    // Last served port, also the active one in ARB_ACCESS
    logic                  last_q;
    logic                  grant;

    assign stb_v       = {b_stb, a_stb};
    assign op_in[0]    = a_op;
    assign op_in[1]    = b_op;
    assign addr_in[0]  = a_addr;
    assign addr_in[1]  = b_addr;
    assign wdata_in[0] = a_wdata;
    assign wdata_in[1] = b_wdata;

    // Request payload, valid while pending
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (stb_v[i]) begin
                op_q[i]    <= op_in[i];
                addr_q[i]  <= addr_in[i];
                wdata_q[i] <= wdata_in[i];
            end
        end
    end

    // Strobe sets, done clears; a strobe on the done cycle keeps the slot full
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (stb_v[i]) begin
                    pend_q[i] <= 1'b1;
                end else if (done_v[i]) begin
                    pend_q[i] <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // Arbitration FSM
    //////////////////////////////

    // Both pending: the port not served last goes first
    assign grant = (pend_q[0] && pend_q[1]) ? ~last_q : pend_q[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ARB_IDLE;
            last_q  <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (|pend_q) begin
                        state_q <= ARB_ACCESS;
                        last_q  <= grant;
                    end
                end
                ARB_ACCESS: state_q <= ARB_IDLE;
                default:    state_q <= ARB_IDLE;
            endcase
        end
    end

    // Bus access issued from idle
    assign bus_en    = (state_q == ARB_IDLE) && (|pend_q);
    assign bus_op    = op_q[grant];
    assign bus_addr  = gpio_reg_t'(addr_q[grant]);
    assign bus_wdata = wdata_q[grant];

    // Completion to the served port
    assign done_v  = (state_q == ARB_ACCESS) ? (last_q ? 2'b10 : 2'b01) : 2'b00;
    assign a_done  = done_v[0];
    assign b_done  = done_v[1];
    assign a_rdata = (done_v[0] && op_q[0] == BUS_READ) ? bus_rdata : '0;
    assign b_rdata = (done_v[1] && op_q[1] == BUS_READ) ? bus_rdata : '0;

endmodule : bus_arbiter

// File: rtl/gpio_top.sv
// GPIO peripheral top: two host ports, arbiter, registers, input sync
// gpio_in is asynchronous; everything else is in the clk domain
// Hosts must wait for done before strobing again

`timescale 1ns/1ps

module gpio_top import gpio_pkg::*, bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // Host port a
    input  logic                  a_stb,
    input  bus_op_t               a_op,
    input  logic [REG_ADDR_W-1:0] a_addr,
    input  logic [GPIO_W-1:0]     a_wdata,
    output logic                  a_done,
    output logic [GPIO_W-1:0]     a_rdata,
    // Host port b
    input  logic                  b_stb,
    input  bus_op_t               b_op,
    input  logic [REG_ADDR_W-1:0] b_addr,
    input  logic [GPIO_W-1:0]     b_wdata,
    output logic                  b_done,
    output logic [GPIO_W-1:0]     b_rdata,
    // Pins
    input  logic [GPIO_W-1:0]     gpio_in,
    output logic [GPIO_W-1:0]     gpio_out,
    output logic [GPIO_W-1:0]     gpio_oe,
    // Interrupt level
    output logic                  irq
);

    //////////////////////////////
    // Internal register bus
    //////////////////////////////

    logic              bus_en;
    bus_op_t           bus_op;
    gpio_reg_t         bus_addr;
    logic [GPIO_W-1:0] bus_wdata;
    logic [GPIO_W-1:0] bus_rdata;

    // Sync path
    logic [GPIO_W-1:0] gpio_sync_val;
    logic [GPIO_W-1:0] gpio_ien;

    bus_arbiter u_arb (
        .clk(clk), .rst(rst),
        .a_stb(a_stb), .a_op(a_op), .a_addr(a_addr), .a_wdata(a_wdata),
        .a_done(a_done), .a_rdata(a_rdata),
        .b_stb(b_stb), .b_op(b_op), .b_addr(b_addr), .b_wdata(b_wdata),
        .b_done(b_done), .b_rdata(b_rdata),
        .bus_en(bus_en), .bus_op(bus_op), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata)
    );

    gpio_regs u_regs (
        .clk(clk), .rst(rst),
        .bus_en(bus_en), .bus_op(bus_op), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
        .gpio_sync_val(gpio_sync_val), .gpio_ien(gpio_ien),
        .gpio_out(gpio_out), .gpio_oe(gpio_oe), .irq(irq)
    );

    // Pins enter the clk domain here
    gpio_sync u_sync (
        .clk(clk), .rst(rst),
        .gpio_in(gpio_in), .gpio_ien(gpio_ien),
        .gpio_sync_val(gpio_sync_val)
    );

endmodule : gpio_top

// File: testbench/gpio_chk.sv
// Bus protocol assertions for gpio_top, attached by bind
// Tracks each host port's open request from strobe to done
// Sees only top level ports and the internal bus_en

`timescale 1ns/1ps

module gpio_chk (
    input logic clk,
    input logic rst,
    input logic bus_en,
    input logic a_stb,
    input logic a_done,
    input logic b_stb,
    input logic b_done
);

    // Open request per port
    logic a_busy;
    logic b_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_busy <= 1'b0;
            b_busy <= 1'b0;
        end else begin
            a_busy <= a_stb || (a_busy && !a_done);
            b_busy <= b_stb || (b_busy && !b_done);
        end
    end

    //////////////////////////////
    // Protocol properties
    //////////////////////////////

    // One cycle per bus access
    bus_en_single: assert property (@(posedge clk) disable iff (rst) bus_en |=> !bus_en)
        else $error("bus_en high in two consecutive cycles");

    done_exclusive: assert property (@(posedge clk) disable iff (rst) !(a_done && b_done))
        else $error("a_done and b_done high in the same cycle");

    // Strobe in the done cycle is fine, the slot frees there
    a_stb_idle: assert property (@(posedge clk) disable iff (rst) a_stb |-> (!a_busy || a_done))
        else $error("port a strobed with a request still open");

    b_stb_idle: assert property (@(posedge clk) disable iff (rst) b_stb |-> (!b_busy || b_done))
        else $error("port b strobed with a request still open");

endmodule : gpio_chk

bind gpio_top gpio_chk u_chk (
    .clk(clk), .rst(rst), .bus_en(bus_en),
    .a_stb(a_stb), .a_done(a_done),
    .b_stb(b_stb), .b_done(b_done)
);

// File: testbench/gpio_tb.sv
// Pattern-driven testbench for gpio_top
// Pattern file path is relative to the project root, so run from there
// Each pattern sets the pins, waits out the synchronizer, then strobes
// Pin output expectations are shadowed from the writes issued here

`timescale 1ns/1ps

module gpio_tb import gpio_pkg::*, bus_pkg::*; ();

    logic                  clk;
    logic                  rst;
    logic                  a_stb;
    bus_op_t               a_op;
    logic [REG_ADDR_W-1:0] a_addr;
    logic [GPIO_W-1:0]     a_wdata;
    logic                  a_done;
    logic [GPIO_W-1:0]     a_rdata;
    logic                  b_stb;
    bus_op_t               b_op;
    logic [REG_ADDR_W-1:0] b_addr;
    logic [GPIO_W-1:0]     b_wdata;
    logic                  b_done;
    logic [GPIO_W-1:0]     b_rdata;
    logic [GPIO_W-1:0]     gpio_in;
    logic [GPIO_W-1:0]     gpio_out;
    logic [GPIO_W-1:0]     gpio_oe;
    logic                  irq;

    // Current access per port with index 0 for port a
    logic [31:0]           op_f    [2];
    logic [31:0]           addr_f  [2];
    logic [31:0]           wdata_f [2];
    logic [31:0]           exp_f   [2];
    // Last record read from the file
    logic [31:0]           r_kind;
    logic [31:0]           r_op;
    logic [31:0]           r_addr;
    logic [31:0]           r_wdata;
    logic [31:0]           r_pin;
    logic [31:0]           r_exp;
    logic [31:0]           r_irq;
    // Expected pin outputs
    logic [GPIO_W-1:0]     out_sh;
    logic [GPIO_W-1:0]     oe_sh;

    gpio_top dut (
        .clk(clk), .rst(rst),
        .a_stb(a_stb), .a_op(a_op), .a_addr(a_addr), .a_wdata(a_wdata),
        .a_done(a_done), .a_rdata(a_rdata),
        .b_stb(b_stb), .b_op(b_op), .b_addr(b_addr), .b_wdata(b_wdata),
        .b_done(b_done), .b_rdata(b_rdata),
        .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe), .irq(irq)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic abort(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input logic [GPIO_W-1:0] got,
                         input logic [GPIO_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            abort("value mismatch");
        end
    endtask

    // Reads the next data line and skips comment lines
    task automatic read_record(input int fd, output bit found);
        int              n;
        logic [8*96-1:0] rest;
        found = 1'b0;
        while (!found && !$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h", r_kind, r_op, r_addr, r_wdata,
                        r_pin, r_exp, r_irq);
            if (n == 7) begin
                found = 1'b1;
            end else if (n > 0) begin
                abort("malformed line in pattern file");
            end else begin
                void'($fgets(rest, fd));
            end
        end
    endtask

    task automatic take_record(input int idx);
        op_f[idx]    = r_op;
        addr_f[idx]  = r_addr;
        wdata_f[idx] = r_wdata;
        exp_f[idx]   = r_exp;
    endtask

    task automatic apply_pins(input logic [GPIO_W-1:0] pins);
        @(posedge clk);
        gpio_in <= pins;
        // Sync chain plus edge capture and a random gap
        repeat (SYNC_STAGES + 2) @(posedge clk);
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic strobe_ports(input bit use_a, input bit use_b);
        @(posedge clk);
        if (use_a) begin
            a_stb   <= 1'b1;
            a_op    <= op_f[0][0] ? BUS_WRITE : BUS_READ;
            a_addr  <= addr_f[0][REG_ADDR_W-1:0];
            a_wdata <= wdata_f[0][GPIO_W-1:0];
        end
        if (use_b) begin
            b_stb   <= 1'b1;
            b_op    <= op_f[1][0] ? BUS_WRITE : BUS_READ;
            b_addr  <= addr_f[1][REG_ADDR_W-1:0];
            b_wdata <= wdata_f[1][GPIO_W-1:0];
        end
        @(posedge clk);
        a_stb <= 1'b0;
        b_stb <= 1'b0;
    endtask

    // One done per active port with rdata checked on it
    task automatic wait_done(input bit use_a, input bit use_b);
        int cycles;
        bit seen_a;
        bit seen_b;
        cycles = 0;
        seen_a = 1'b0;
        seen_b = 1'b0;
        while ((seen_a != use_a) || (seen_b != use_b)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                abort("timeout waiting for done");
            end
            if (a_done) begin
                if (!use_a || seen_a) begin
                    abort("unexpected done on port a");
                end
                seen_a = 1'b1;
                check("a_rdata", a_rdata, exp_f[0][GPIO_W-1:0]);
            end
            if (b_done) begin
                if (!use_b || seen_b) begin
                    abort("unexpected done on port b");
                end
                seen_b = 1'b1;
                check("b_rdata", b_rdata, exp_f[1][GPIO_W-1:0]);
            end
        end
        // No stray done after the access
        repeat (2) begin
            @(negedge clk);
            if (a_done || b_done) begin
                abort("extra done pulse after the access");
            end
        end
    endtask

    task automatic track_writes(input bit use_a, input bit use_b);
        for (int i = 0; i < 2; i++) begin
            if (((i == 0) ? use_a : use_b) && op_f[i][0]) begin
                if (addr_f[i][REG_ADDR_W-1:0] == REG_OUT) begin
                    out_sh = wdata_f[i][GPIO_W-1:0];
                end
                if (addr_f[i][REG_ADDR_W-1:0] == REG_OE) begin
                    oe_sh = wdata_f[i][GPIO_W-1:0];
                end
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int                fd;
        bit                found;
        bit                use_a;
        bit                use_b;
        logic [GPIO_W-1:0] pin_v;
        void'($urandom(32'h094c_e2d8));
        rst     = 1'b1;
        a_stb   = 1'b0;
        a_op    = BUS_READ;
        a_addr  = '0;
        a_wdata = '0;
        b_stb   = 1'b0;
        b_op    = BUS_READ;
        b_addr  = '0;
        b_wdata = '0;
        gpio_in = '0;
        out_sh  = '0;
        oe_sh   = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("gpio_out", gpio_out, '0);
        check("gpio_oe", gpio_oe, '0);
        check("irq", GPIO_W'(irq), '0);
        fd = $fopen("testbench/gpio_patterns.txt", "r");
        if (fd == 0) begin
            abort("cannot open testbench/gpio_patterns.txt");
        end
        read_record(fd, found);
        while (found) begin
            use_a = (r_kind == 32'ha) || (r_kind == 32'hab);
            use_b = (r_kind == 32'hb);
            if (!use_a && !use_b) begin
                abort("unknown port code in pattern file");
            end
            take_record(use_b ? 1 : 0);
            pin_v = r_pin[GPIO_W-1:0];
            // Same-cycle pair takes the b access from the next line
            if (r_kind == 32'hab) begin
                read_record(fd, found);
                if (!found || r_kind != 32'hb) begin
                    abort("ab line in pattern file not followed by a b line");
                end
                use_b = 1'b1;
                take_record(1);
            end
            apply_pins(pin_v);
            strobe_ports(use_a, use_b);
            wait_done(use_a, use_b);
            track_writes(use_a, use_b);
            check("gpio_out", gpio_out, out_sh);
            check("gpio_oe", gpio_oe, oe_sh);
            check("irq", GPIO_W'(irq), GPIO_W'(r_irq[0]));
            read_record(fd, found);
        end
        $fclose(fd);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : gpio_tb

// File: testbench/gpio_patterns.txt
# kind op reg wdata pin exp_rdata exp_irq, all hex; kind a, b or ab (a, paired with next b)
# op 0 read, 1 write; pins are applied before the access
a 0 0 00 00 00 0
b 0 1 00 00 00 0
a 0 2 00 00 00 0
b 0 3 00 ff 00 0
a 0 4 00 ff 00 0
b 0 5 00 ff 00 0
a 0 6 00 ff 00 0
b 0 7 00 ff 00 0
a 1 0 a5 ff 00 0
a 0 0 00 ff a5 0
b 1 1 3c ff 00 0
b 0 1 00 ff 3c 0
a 1 5 0f ff 00 0
a 1 2 f0 00 00 0
b 0 2 00 00 f0 0
b 0 3 00 5a 50 0
a 0 4 00 5a 50 0
a 1 5 ff 5a 00 1
a 1 4 50 5a 00 0
b 0 4 00 fa a0 1
ab 1 0 c3 fa 00 1
b 1 1 81 fa 00 1
ab 0 0 00 fa c3 1
b 0 1 00 fa 81 1
a 1 7 ff fa 00 1
a 0 0 00 fa c3 1
b 0 5 00 fa ff 1
b 1 4 ff fa 00 0
a 0 4 00 fa 00 0
b 0 6 00 fa 00 0

// File: sim.f
rtl/gpio_pkg.sv
rtl/bus_pkg.sv
rtl/gpio_sync.sv
rtl/gpio_regs.sv
rtl/bus_arbiter.sv
rtl/gpio_top.sv
testbench/gpio_chk.sv
testbench/gpio_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the GPIO testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module gpio_tb -f sim.f -o gpio_sim &&
./obj_dir/gpio_sim ||
{ echo "GPIO simulation did not pass"; exit 1; }
